//--- gf3_coproc.f
logic/gf3_pkg.sv
logic/microcode_pkg.sv
logic/alu_ctrl_if.sv
logic/command_rom.sv
logic/operand_ram.sv
logic/gf3_serial_alu.sv
logic/micro_sequencer.sv
logic/gf3_coproc.sv
testbench/tb_clock_gen.sv
testbench/gf3_coproc_tb.sv

//--- testbench/gf3_coproc_tb.sv
`default_nettype none

module gf3_coproc_tb
    import gf3_pkg::*, microcode_pkg::*;
();

    localparam int num_runs      = 4;
    localparam int done_timeout  = 500;    // a full program takes about 100 cycles
    localparam int reset_timeout = 20;

    logic                      clk;
    logic                      reset;
    logic                      start;
    logic                      done;
    logic                      host_we;
    logic [ram_addr_width-1:0] host_addr;
    gf_elem_t                  host_wdata;
    gf_elem_t                  host_rdata;

    logic                      check_valid;    // host_rdata is compared on this edge
    logic [ram_addr_width-1:0] check_addr;
    gf_elem_t                  check_value;
    logic                      run_pending;    // start given, done not yet seen
    logic [31:0]               rng_state;
    gf_elem_t                  expect_r [0:7];

    tb_clock_gen i_clk (
        .clk   (clk),
        .reset (reset)
    );

    gf3_coproc i_dut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .done       (done),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic gf_elem_t field_add(input gf_elem_t x, input gf_elem_t y);
        gf_elem_t r;
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = 2'((int'(x[2*i +: 2]) + int'(y[2*i +: 2])) % 3);
        return r;
    endfunction

    function automatic gf_elem_t field_sub(input gf_elem_t x, input gf_elem_t y);
        gf_elem_t r;
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = 2'((int'(x[2*i +: 2]) + 3 - int'(y[2*i +: 2])) % 3);
        return r;
    endfunction

    // schoolbook product, then x^k folded as x^(k-4) + 2x^(k-5) since x^5 = x + 2
    function automatic gf_elem_t field_mul(input gf_elem_t x, input gf_elem_t y);
        int       prod [0:8];
        gf_elem_t r;
        for (int k = 0; k < 9; k++)
            prod[k] = 0;
        for (int i = 0; i < gf_m; i++)
            for (int j = 0; j < gf_m; j++)
                prod[i+j] += int'(x[2*i +: 2]) * int'(y[2*j +: 2]);
        for (int k = 8; k >= gf_m; k--)
        begin
            prod[k-4] += prod[k];
            prod[k-5] += 2 * prod[k];
            prod[k]    = 0;
        end
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = 2'(prod[i] % 3);
        return r;
    endfunction

    function automatic gf_elem_t field_cube(input gf_elem_t x);
        return field_mul(field_mul(x, x), x);
    endfunction

    // r0..r7 after one pass of the fixed program
    task automatic compute_expected(input gf_elem_t a, input gf_elem_t b, input gf_elem_t c);
        gf_elem_t r6;
        gf_elem_t r7;
        gf_elem_t r2;
        expect_r[0] = a;
        expect_r[1] = b;
        expect_r[3] = field_mul(a, b);
        expect_r[4] = field_cube(expect_r[3]);
        expect_r[5] = field_add(expect_r[4], c);
        r6 = field_sub(expect_r[5], a);
        for (int p = 0; p < loop1_passes; p++)
            r6 = field_add(field_mul(r6, b), c);
        r7 = r6;
        for (int p = 0; p < gf_m; p++)
            r7 = field_cube(r7);
        r2 = c;
        for (int p = 0; p < loop2_passes; p++)
            r2 = field_add(r2, a);
        expect_r[2] = r2;
        expect_r[6] = r6;
        expect_r[7] = r7;
    endtask

    task automatic random_element(output gf_elem_t e);
        for (int i = 0; i < gf_m; i++)
        begin
            rng_state   = xorshift32(rng_state);
            e[2*i +: 2] = 2'(rng_state % 3);    // codes 0..2 only
        end
    endtask

    task automatic load_word(input logic [ram_addr_width-1:0] addr, input gf_elem_t value);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= value;
        @(posedge clk);
        host_we    <= 1'b0;
    endtask

    task automatic expect_word(input logic [ram_addr_width-1:0] addr, input gf_elem_t value);
        @(posedge clk);
        host_addr   <= addr;
        @(posedge clk);    // ram registers the word here
        check_valid <= 1'b1;
        check_addr  <= addr;
        check_value <= value;
        @(posedge clk);
        check_valid <= 1'b0;
    endtask

    task automatic await_reset();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (reset && cycles < reset_timeout);
        if (reset)
        begin
            $display("reset was still high after %0d cycles", reset_timeout);
            $display("** FAIL **");
            $fatal(1, "reset never released");
        end
    endtask

    task automatic run_program();
        int cycles;
        @(posedge clk);
        start       <= 1'b1;
        run_pending <= 1'b1;
        @(posedge clk);
        start       <= 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!done && cycles < done_timeout);
        if (!done)
        begin
            $display("done did not arrive within %0d cycles of start", done_timeout);
            $display("** FAIL **");
            $fatal(1, "timeout waiting for done");
        end
        @(posedge clk);
        run_pending <= 1'b0;    // done drops on this same edge
    endtask

    a_read_value: assert property (
        @(posedge clk) disable iff (reset) check_valid |-> host_rdata == check_value
    )
    else
    begin
        $display("MISMATCH at %0t: r%0d read %h, expected %h", $time,
                 $sampled(check_addr), $sampled(host_rdata), $sampled(check_value));
        $display("** FAIL **");
        $fatal(1, "register readback differs from the field model");
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    )
    else
    begin
        $display("done stayed high for more than one cycle at %0t", $time);
        $display("** FAIL **");
        $fatal(1, "done is not a single-cycle pulse");
    end

    a_done_after_start: assert property (
        @(posedge clk) disable iff (reset) done |-> run_pending
    )
    else
    begin
        $display("done went high at %0t without a pending start", $time);
        $display("** FAIL **");
        $fatal(1, "unexpected done");
    end

    initial
    begin
        gf_elem_t a;
        gf_elem_t b;
        gf_elem_t c;
        start       = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        check_valid = 1'b0;
        check_addr  = '0;
        check_value = '0;
        run_pending = 1'b0;
        rng_state   = 32'd97161;
        await_reset();
        for (int run = 0; run < num_runs; run++)
        begin
            random_element(a);
            random_element(b);
            random_element(c);
            load_word(4'd0, a);
            load_word(4'd1, b);
            load_word(4'd2, c);
            expect_word(4'd0, a);    // idle readback before the run
            expect_word(4'd1, b);
            expect_word(4'd2, c);
            compute_expected(a, b, c);
            run_program();
            for (int k = 0; k < 8; k++)
                expect_word(4'(k), expect_r[k]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;    // period 10

    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;    // eight edges see reset high
    end

endmodule

`default_nettype wire

//--- logic/gf3_coproc.sv
`default_nettype none

module gf3_coproc
    import gf3_pkg::*, microcode_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    output logic                      done,
    input  logic                      host_we,
    input  logic [ram_addr_width-1:0] host_addr,
    input  gf_elem_t                  host_wdata,
    output gf_elem_t                  host_rdata
);

    logic [rom_addr_width-1:0] rom_addr;
    cmd_t                      cmd;
    logic [ram_addr_width-1:0] ram_a_addr;
    gf_elem_t                  ram_a_rdata;
    logic [ram_addr_width-1:0] seq_b_addr;
    logic                      seq_b_we;
    logic                      busy;
    gf_elem_t                  alu_result;
    logic [ram_addr_width-1:0] ram_b_addr;
    logic                      ram_b_we;
    gf_elem_t                  ram_b_wdata;

    alu_ctrl_if i_ctrl ();

    command_rom i_rom (
        .addr (rom_addr),
        .cmd  (cmd)
    );

    micro_sequencer i_seq (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cmd        (cmd),
        .rom_addr   (rom_addr),
        .ram_a_addr (ram_a_addr),
        .ram_b_addr (seq_b_addr),
        .ram_b_we   (seq_b_we),
        .ctrl       (i_ctrl.sequencer),
        .busy       (busy),
        .done       (done)
    );

    // host owns port b whenever the sequencer is idle
    assign ram_b_addr  = busy ? seq_b_addr : host_addr;
    assign ram_b_we    = busy ? seq_b_we : host_we;
    assign ram_b_wdata = busy ? alu_result : host_wdata;

    operand_ram i_ram (
        .clk     (clk),
        .a_addr  (ram_a_addr),
        .a_rdata (ram_a_rdata),
        .b_addr  (ram_b_addr),
        .b_we    (ram_b_we),
        .b_wdata (ram_b_wdata),
        .b_rdata (host_rdata)    // one cycle after host_addr
    );

    gf3_serial_alu i_alu (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (i_ctrl.alu),
        .a_data (ram_a_rdata),
        .result (alu_result)
    );

    // a host write during a run would be dropped by the mux
    a_no_host_write_busy: assert property (
        @(posedge clk) disable iff (reset) busy |-> !host_we
    );

endmodule

`default_nettype wire

//--- logic/micro_sequencer.sv
`default_nettype none

module micro_sequencer
    import microcode_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  cmd_t                      cmd,
    output logic [rom_addr_width-1:0] rom_addr,
    output logic [ram_addr_width-1:0] ram_a_addr,
    output logic [ram_addr_width-1:0] ram_b_addr,
    output logic                      ram_b_we,
    alu_ctrl_if.sequencer             ctrl,
    output logic                      busy,
    output logic                      done
);

    typedef enum logic [6:0] {
        st_idle      = 7'b0000001,
        st_read_src1 = 7'b0000010,
        st_read_src2 = 7'b0000100,
        st_calc      = 7'b0001000,
        st_wait      = 7'b0010000,
        st_write     = 7'b0100000,
        st_halt      = 7'b1000000
    } state_t;

    state_t                    state;
    logic [times_width-1:0]    count;       // remaining calc cycles
    logic [ram_addr_width-1:0] dest_q;      // rom moves on before the write
    logic [loop1_passes-2:0]   loop1;       // one bit per jump back
    logic [loop2_passes-2:0]   loop2;
    logic                      first_calc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (start)
                        state <= st_read_src1;
                end
                st_read_src1: state <= st_read_src2;
                st_read_src2:
                begin
                    if (cmd.times == '0)
                        state <= st_halt;
                    else
                        state <= st_calc;
                end
                st_calc:
                begin
                    if (count == 3'd1)
                        state <= st_wait;
                end
                st_wait:  state <= st_write;
                st_write: state <= st_read_src1;
                st_halt:  state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // program counter, rewound for the next run at halt
    always_ff @(posedge clk)
    begin
        if (reset || state == st_halt)
        begin
            rom_addr <= '0;
        end
        else if (state == st_wait)
        begin
            if (rom_addr == loop1_end && loop1[0])
                rom_addr <= loop1_start;
            else if (rom_addr == loop2_end && loop2[0])
                rom_addr <= loop2_start;
            else
                rom_addr <= rom_addr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || state == st_halt)
        begin
            loop1 <= '1;
            loop2 <= '1;
        end
        else if (state == st_wait)
        begin
            if (rom_addr == loop1_end)
                loop1 <= loop1 >> 1;
            if (rom_addr == loop2_end)
                loop2 <= loop2 >> 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (state == st_read_src1)
            count <= cmd.times;
        else if (state == st_calc)
            count <= count - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (state == st_wait)
            dest_q <= cmd.dest;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            done <= 1'b0;
        else
            done <= (state == st_halt);    // one cycle after halt
    end

    always_comb
    begin
        case (state)
            st_read_src1: ram_a_addr = cmd.src1;
            st_read_src2: ram_a_addr = cmd.src2;
            default:      ram_a_addr = '0;
        endcase
    end

    assign ram_b_addr = (state == st_write) ? dest_q : '0;
    assign ram_b_we   = (state == st_write);
    assign busy       = (state != st_idle);

    // src1 data is on port a during read_src2, src2 data in the first calc
    assign first_calc  = (state == st_calc) && (count == cmd.times);
    assign ctrl.load_a = (state == st_read_src2);
    assign ctrl.load_b = first_calc;
    assign ctrl.first  = first_calc;
    assign ctrl.step   = (state == st_calc);
    assign ctrl.op     = cmd.op;

    a_state_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot(state)
    );

    // first-step detection compares count against times
    a_times_stable: assert property (
        @(posedge clk) disable iff (reset) (state == st_calc) |-> $stable(cmd.times)
    );

endmodule

`default_nettype wire

//--- logic/gf3_serial_alu.sv
`default_nettype none

module gf3_serial_alu
    import gf3_pkg::*, microcode_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    alu_ctrl_if.alu        ctrl,
    input  gf_elem_t       a_data,
    output gf_elem_t       result
);

    gf_elem_t a_reg;
    gf_elem_t b_reg;       // shifts up one coefficient per multiply step
    gf_elem_t acc;
    gf_elem_t b_cur;
    gf_elem_t b_next;
    gf_elem_t acc_next;

    function automatic logic [1:0] coef_add(logic [1:0] x, logic [1:0] y);
        logic [2:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= 3'd3)
        begin
            s = s - 3'd3;
        end
        return s[1:0];
    endfunction

    function automatic logic [1:0] coef_neg(logic [1:0] x);
        case (x)
            coef_one: return coef_two;
            coef_two: return coef_one;
            default:  return coef_zero;
        endcase
    endfunction

    function automatic logic [1:0] coef_mul(logic [1:0] x, logic [1:0] y);
        if (x == coef_zero || y == coef_zero)
            return coef_zero;
        else if (x == y)
            return coef_one;    // 1*1 and 2*2
        else
            return coef_two;
    endfunction

    function automatic gf_elem_t elem_add(gf_elem_t x, gf_elem_t y);
        gf_elem_t r;
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = coef_add(x[2*i +: 2], y[2*i +: 2]);
        return r;
    endfunction

    function automatic gf_elem_t elem_sub(gf_elem_t x, gf_elem_t y);
        gf_elem_t r;
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = coef_add(x[2*i +: 2], coef_neg(y[2*i +: 2]));
        return r;
    endfunction

    function automatic gf_elem_t elem_scale(gf_elem_t x, logic [1:0] c);
        gf_elem_t r;
        for (int i = 0; i < gf_m; i++)
            r[2*i +: 2] = coef_mul(x[2*i +: 2], c);
        return r;
    endfunction

    // x * e, with x^5 folded back as -(2x + 1)
    function automatic gf_elem_t elem_times_x(gf_elem_t e);
        return elem_sub(e << 2, elem_scale(gf_poly_low, e[gf_width-1 -: 2]));
    endfunction

    // Frobenius map, images of x^0..x^4 are 1, x^3, x^2+2x, 2x^4+x+2, x^4+x^3+x^2
    function automatic gf_elem_t elem_cube(gf_elem_t e);
        gf_elem_t r;
        r[1:0] = coef_add(e[1:0], coef_neg(e[7:6]));
        r[3:2] = coef_add(coef_neg(e[5:4]), e[7:6]);
        r[5:4] = coef_add(e[5:4], e[9:8]);
        r[7:6] = coef_add(e[3:2], e[9:8]);
        r[9:8] = coef_add(coef_neg(e[7:6]), e[9:8]);
        return r;
    endfunction

    assign b_cur = ctrl.load_b ? a_data : b_reg;    // b arrives with the first step

    always_comb
    begin
        acc_next = acc;
        b_next   = b_cur;
        case (ctrl.op)
            op_add:   acc_next = elem_add(a_reg, b_cur);
            op_sub:   acc_next = elem_sub(a_reg, b_cur);
            op_cubic: acc_next = elem_cube(ctrl.first ? a_reg : acc);
            op_mult:
            begin
                // horner, top coefficient of b first
                acc_next = elem_add(ctrl.first ? '0 : elem_times_x(acc),
                                    elem_scale(a_reg, b_cur[gf_width-1 -: 2]));
                b_next   = b_cur << 2;
            end
            default:  acc_next = acc;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.load_a)
            a_reg <= a_data;
        if (ctrl.step)
            b_reg <= b_next;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            acc <= '0;
        else if (ctrl.step)
            acc <= acc_next;
    end

    assign result = acc;

    // operand a must be settled before any compute cycle of the command
    a_no_load_in_step: assert property (
        @(posedge clk) disable iff (reset) !(ctrl.step && ctrl.load_a)
    );

endmodule

`default_nettype wire

//--- logic/operand_ram.sv
`default_nettype none

module operand_ram
    import gf3_pkg::*, microcode_pkg::*;
(
    input  logic                      clk,
    input  logic [ram_addr_width-1:0] a_addr,
    output gf_elem_t                  a_rdata,
    input  logic [ram_addr_width-1:0] b_addr,
    input  logic                      b_we,
    input  gf_elem_t                  b_wdata,
    output gf_elem_t                  b_rdata
);

    gf_elem_t mem [0:(1 << ram_addr_width)-1];

    // port a, read only
    always_ff @(posedge clk)
    begin
        a_rdata <= mem[a_addr];
    end

    // port b, read returns the old word on a write
    always_ff @(posedge clk)
    begin
        if (b_we)
        begin
            mem[b_addr] <= b_wdata;
        end
        b_rdata <= mem[b_addr];
    end

    // host or alu must never store an illegal coefficient code
    a_legal_write: assert property (
        @(posedge clk) b_we |-> gf_is_legal(b_wdata)
    )
    else
    begin
        $error("illegal coefficient code written to r%0d: %h", b_addr, b_wdata);
    end

endmodule

`default_nettype wire

//--- logic/command_rom.sv
`default_nettype none

module command_rom
    import microcode_pkg::*;
(
    input  logic [rom_addr_width-1:0] addr,
    output cmd_t                      cmd
);

    always_comb
    begin
        case (addr)
            4'd0: cmd = '{dest: 4'd3, src1: 4'd0, op: op_mult, times: 3'd5, src2: 4'd1};
            // single cube of the product
            4'd1: cmd = '{dest: 4'd4, src1: 4'd3, op: op_cubic, times: 3'd1, src2: 4'd3};
            4'd2: cmd = '{dest: 4'd5, src1: 4'd4, op: op_add, times: 3'd1, src2: 4'd2};
            4'd3: cmd = '{dest: 4'd6, src1: 4'd5, op: op_sub, times: 3'd1, src2: 4'd0};
            // loop 1 body, three passes over r6
            4'd4: cmd = '{dest: 4'd6, src1: 4'd6, op: op_mult, times: 3'd5, src2: 4'd1};
            4'd5: cmd = '{dest: 4'd6, src1: 4'd6, op: op_add, times: 3'd1, src2: 4'd2};
            // five cubes bring r6 back to itself
            4'd6: cmd = '{dest: 4'd7, src1: 4'd6, op: op_cubic, times: 3'd5, src2: 4'd6};
            // loop 2, adds r0 into r2 four times
            4'd7: cmd = '{dest: 4'd2, src1: 4'd2, op: op_add, times: 3'd1, src2: 4'd0};
            4'd8: cmd = '{dest: 4'd0, src1: 4'd0, op: op_add, times: 3'd0, src2: 4'd0};
            default:
            begin
                cmd = '{dest: 4'd0, src1: 4'd0, op: op_add, times: 3'd0, src2: 4'd0};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/alu_ctrl_if.sv
`default_nettype none

interface alu_ctrl_if
    import microcode_pkg::*;
();
    logic load_a;    // capture port a read data as operand a
    logic load_b;    // capture port a read data as operand b
    logic step;      // one compute cycle
    logic first;     // first step of a command, seeds the accumulator
    op_t  op;

    modport sequencer (
        output load_a,
        output load_b,
        output step,
        output first,
        output op
    );

    modport alu (
        input load_a,
        input load_b,
        input step,
        input first,
        input op
    );

endinterface

`default_nettype wire

//--- logic/microcode_pkg.sv
`default_nettype none

package microcode_pkg;

    localparam int ram_addr_width = 4;    // 16 operand words
    localparam int rom_addr_width = 4;    // 16 command slots
    localparam int times_width    = 3;    // compute cycles per command

    // alu operations, two bits in the command word
    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_cubic = 2'd2,
        op_mult  = 2'd3
    } op_t;

    // 17-bit command word, msb first
    typedef struct packed {
        logic [ram_addr_width-1:0] dest;
        logic [ram_addr_width-1:0] src1;
        op_t                       op;
        logic [times_width-1:0]    times;    // zero means halt
        logic [ram_addr_width-1:0] src2;
    } cmd_t;

    // hardware loop 1 covers addresses 4..5
    localparam logic [rom_addr_width-1:0] loop1_start  = 4'd4;
    localparam logic [rom_addr_width-1:0] loop1_end    = 4'd5;
    localparam int                        loop1_passes = 3;

    // hardware loop 2 is the single command at 7
    localparam logic [rom_addr_width-1:0] loop2_start  = 4'd7;
    localparam logic [rom_addr_width-1:0] loop2_end    = 4'd7;
    localparam int                        loop2_passes = 4;

endpackage

`default_nettype wire

//--- logic/gf3_pkg.sv
`default_nettype none

package gf3_pkg;

    localparam int gf_m     = 5;           // field degree
    localparam int gf_width = 2 * gf_m;    // two bits per base-3 coefficient

    // element layout, coefficient i sits at bits 2i+1..2i
    typedef logic [gf_width-1:0] gf_elem_t;

    // coefficient codes
    localparam logic [1:0] coef_zero    = 2'd0;
    localparam logic [1:0] coef_one     = 2'd1;
    localparam logic [1:0] coef_two     = 2'd2;
    localparam logic [1:0] coef_illegal = 2'd3;    // never stored

    // x^5 + 2x + 1, low part only; the multiply step subtracts top * this
    localparam gf_elem_t gf_poly_low = {coef_zero, coef_zero, coef_zero, coef_two, coef_one};

    // true when no coefficient carries the illegal code
    function automatic logic gf_is_legal(gf_elem_t e);
        for (int i = 0; i < gf_m; i++)
        begin
            if (e[2*i +: 2] == coef_illegal)
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

endpackage

`default_nettype wire
